/* flist.f */
+incdir+include
src/mem_map_pkg.sv
src/access_pkg.sv
src/dmem_byte_ram.sv
src/dmem_lane_align.sv
src/dmem_apb_slave.sv
src/dmem_top.sv
verif/tb_dmem.sv

/* include/tb_lfsr.svh */
`ifndef TB_LFSR_SVH
`define TB_LFSR_SVH

// random source for the testbench, a 32-bit Galois LFSR shifted right
// taps 32, 31, 29 and 1 give a maximal length sequence
logic [31:0] lfsr_state = 32'h3713_075e;   // fixed seed, every run draws the same fields

function automatic logic next_lfsr_bit();
    logic out;
    out        = lfsr_state[0];                                   // bit leaving the register
    lfsr_state = (lfsr_state >> 1) ^ (out ? 32'hd000_0001 : 32'h0);
    return out;
endfunction

// builds a field of n bits, one LFSR step per bit, msb drawn first
function automatic logic [31:0] random_field(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
        value = {value[30:0], next_lfsr_bit()};
    end
    return value;
endfunction

`endif

/* verif/tb_dmem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dmem;

    import mem_map_pkg::*;

    localparam int window_bytes = 2 ** dmem_addr_width_dflt;   // bytes the RAM answers for
    localparam int region_bytes = 256;                          // test region at the window start
    localparam int wait_limit   = 10;                           // access cycles before a timeout

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [2:0]  access_kind;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [7:0]  model_mem [0:window_bytes-1];   // expected contents, X until written
    logic        written   [0:window_bytes-1];   // bytes the testbench has stored

    `include "tb_lfsr.svh"

    dmem_top #(
        .MEM_ADDR_WIDTH (dmem_addr_width_dflt)
    ) uut (
        .clk         (clk),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .access_kind (access_kind),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                   // 100 ns period
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h expected %h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // byte count of a kind, from the funct3 size field
    function automatic int access_size(input logic [2:0] kind);
        case (kind[1:0])
            2'b00:   return 1;
            2'b01:   return 2;
            default: return 4;
        endcase
    endfunction

    function automatic void update_model(input int off, input logic [2:0] kind,
                                         input logic [31:0] data);
        for (int i = 0; i < access_size(kind); i++) begin
            model_mem[off + i] = data[8*i +: 8];  // little endian, lowest byte first
            written[off + i]   = 1'b1;
        end
    endfunction

    function automatic logic [31:0] written_mask(input int row_off);
        logic [31:0] mask;
        for (int i = 0; i < 4; i++) begin
            mask[8*i +: 8] = written[row_off + i] ? 8'hff : 8'h00;
        end
        return mask;
    endfunction

    function automatic logic [31:0] expected_load(input int off, input logic [2:0] kind);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = model_mem[off];
        b1 = model_mem[off + 1];
        case (kind)
            3'b000:  return {{24{b0[7]}}, b0};    // lb copies the byte's sign bit
            3'b100:  return {24'h0, b0};
            3'b001:  return {{16{b1[7]}}, b1, b0};
            3'b101:  return {16'h0, b1, b0};
            default: return {model_mem[off + 3], model_mem[off + 2], b1, b0};
        endcase
    endfunction

    function automatic logic [2:0] load_kind(input int sel);
        case (sel)
            0:       return 3'b000;
            1:       return 3'b001;
            2:       return 3'b010;
            3:       return 3'b100;
            default: return 3'b101;
        endcase
    endfunction

    // one APB transfer, cycles counts access phase edges up to and including pready
    task automatic transfer(input logic write, input logic [31:0] addr,
                            input logic [2:0] kind, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output int cycles);
        logic done;
        done   = 1'b0;
        cycles = 0;
        rdata  = '0;
        err    = 1'b0;
        @(negedge clk);
        psel        = 1'b1;                       // setup phase
        penable     = 1'b0;
        pwrite      = write;
        paddr       = addr;
        pwdata      = wdata;
        access_kind = kind;
        @(negedge clk);
        penable = 1'b1;                           // access phase, held until pready
        while (!done) begin
            @(posedge clk);
            cycles++;
            if (pready) begin
                done  = 1'b1;
                rdata = prdata;
                err   = pslverr;                  // only valid on the pready edge
            end else if (cycles >= wait_limit) begin
                $display("timeout: no pready within %0d access cycles at %0t", wait_limit,
                         $time);
                $display("Verification failed");
                $fatal(1, "transfer timed out");
            end
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic store(input int off, input logic [2:0] kind, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        int          cycles;
        transfer(1'b1, dmem_base + off, kind, data, rdata, err, cycles);
        check_value($sformatf("store pslverr at %h", off), 32'(err), 32'h0);
        check_value("store access cycles", cycles, 1);     // no wait state on writes
        update_model(off, kind, data);
    endtask

    task automatic load_and_compare(input int off, input logic [2:0] kind,
                                    input logic [31:0] mask);
        logic [31:0] rdata;
        logic        err;
        int          cycles;
        transfer(1'b0, dmem_base + off, kind, 32'h0, rdata, err, cycles);
        check_value($sformatf("load pslverr at %h", off), 32'(err), 32'h0);
        check_value("load access cycles", cycles, 2);      // one wait state on reads
        check_value($sformatf("load data at %h kind %b", off, kind), rdata & mask,
                    expected_load(off, kind) & mask);
    endtask

    task automatic expect_error(input logic write, input logic [31:0] addr,
                                input logic [2:0] kind);
        logic [31:0] rdata;
        logic        err;
        int          cycles;
        transfer(write, addr, kind, random_field(32), rdata, err, cycles);
        check_value($sformatf("pslverr at %h kind %b", addr, kind), 32'(err), 32'h1);
        check_value("error access cycles", cycles, 1);
    endtask

    initial begin
        int         off;
        int         low;
        int         sel;
        logic [2:0] kind;
        logic [31:0] addr;
        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        access_kind = '0;
        for (int i = 0; i < window_bytes; i++) begin
            written[i] = 1'b0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < 4; i++) begin          // idle bus after reset
            @(posedge clk);
            check_value("idle pready", 32'(pready), 32'h0);
            check_value("idle pslverr", 32'(pslverr), 32'h0);
        end

        // stores of every size, each row read back as a word
        for (int i = 0; i < 200; i++) begin
            sel  = random_field(2);
            kind = (sel == 3) ? 3'b010 : 3'(sel);
            off  = random_field(8);
            off  = off & ~(access_size(kind) - 1);  // aligned to the size
            store(off, kind, random_field(32));
            load_and_compare(off & ~3, 3'b010, written_mask(off & ~3));
        end

        // fill the rest of the region so every load below sees written bytes
        for (int r = 0; r < region_bytes; r += 4) begin
            if (written_mask(r) != 32'hffff_ffff) begin
                store(r, 3'b010, random_field(32));
            end
        end
        for (int i = 0; i < 250; i++) begin
            kind = load_kind(i % 5);                // cycles through all five load kinds
            off  = random_field(8);
            off  = off & ~(access_size(kind) - 1);
            load_and_compare(off, kind, 32'hffff_ffff);
        end

        // illegal accesses, then the row must still hold the model's bytes
        for (int i = 0; i < 90; i++) begin
            off  = random_field(8) & ~3;
            addr = dmem_base + off;
            kind = 3'b010;
            case (i % 5)
                0: begin
                    kind = random_field(1) ? 3'b101 : 3'b001;
                    addr = addr | 32'(2 * random_field(1) + 1);   // odd halfword offset
                end
                1: begin
                    low = random_field(2);
                    addr = addr | ((low == 0) ? 32'd3 : 32'(low));  // word not on a row
                end
                2: addr = addr + window_bytes;       // just above the window
                3: addr = addr - window_bytes;       // below the base
                default: begin
                    low  = random_field(2);
                    kind = (low == 0) ? 3'b011 : ((low == 1) ? 3'b110 : 3'b111);
                end
            endcase
            expect_error(random_field(1), addr, kind);
            load_and_compare(off, 3'b010, 32'hffff_ffff);
        end

        $display("Verification passed");
        $finish;
    end

endmodule : tb_dmem

`default_nettype wire

/* src/dmem_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dmem_top #(
    parameter int MEM_ADDR_WIDTH = mem_map_pkg::dmem_addr_width_dflt   // 4 to 16 bits
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [31:0] paddr,
    input  wire logic [31:0] pwdata,
    input  wire logic [2:0]  access_kind,   // RV32 funct3 of the load or store
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr
);

    import access_pkg::*;

    logic [MEM_ADDR_WIDTH-3:0] row;         // RAM row from the window decode
    logic [1:0]                offset;      // byte lane inside the row
    access_kind_e              kind;        // access kind seen by the aligner
    logic                      wr_en;       // legal write in its first access cycle
    logic                      rd_en;       // legal read in its setup cycle
    lane_word_u                wr_lanes;    // store data placed in its lanes
    logic [3:0]                byte_en;     // lanes written by the store
    lane_word_u                rd_row;      // registered RAM row

    dmem_apb_slave #(
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) u_slave (
        .clk         (clk),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .access_kind (access_kind),
        .pready      (pready),
        .pslverr     (pslverr),
        .row         (row),
        .offset      (offset),
        .kind        (kind),
        .wr_en       (wr_en),
        .rd_en       (rd_en)
    );

    // load_data goes straight out on prdata, the host samples it with pready
    dmem_lane_align u_align (
        .offset    (offset),
        .kind      (kind),
        .wdata     (pwdata),
        .wr_lanes  (wr_lanes),
        .byte_en   (byte_en),
        .rd_row    (rd_row),
        .load_data (prdata)
    );

    dmem_byte_ram #(
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) u_ram (
        .clk      (clk),
        .row      (row),
        .wr_en    (wr_en),
        .byte_en  (byte_en),
        .wr_lanes (wr_lanes),
        .rd_en    (rd_en),
        .rd_row   (rd_row)
    );

endmodule : dmem_top

`default_nettype wire

/* src/dmem_apb_slave.sv */
`timescale 1ns/1ns
`default_nettype none

module dmem_apb_slave #(
    parameter int MEM_ADDR_WIDTH = 12                  // window width in byte address bits
) (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      psel,
    input  wire logic                      penable,
    input  wire logic                      pwrite,
    input  wire logic [31:0]               paddr,
    input  wire logic [2:0]                access_kind, // sideband, held like paddr
    output logic                           pready,
    output logic                           pslverr,
    output logic [MEM_ADDR_WIDTH-3:0]      row,         // RAM row of the access
    output logic [1:0]                     offset,      // byte lane of the access
    output access_pkg::access_kind_e       kind,        // kind handed to the aligner
    output logic                           wr_en,       // RAM write strobe
    output logic                           rd_en        // RAM read strobe
);

    import access_pkg::*;
    import mem_map_pkg::*;

    logic        setup;                                 // first cycle of a transfer
    logic        access;                                // every cycle of the access phase
    logic [31:0] win_addr;                              // address relative to the window base
    logic        in_window;                             // address lies inside the RAM
    logic        kind_ok;                               // funct3 code is one of the five kinds
    logic [1:0]  align_mask;                            // offset bits that must be zero
    logic        aligned;                               // offset is a multiple of the size
    logic        legal;                                 // all three checks pass
    logic        rd_pending;                            // a legal read was issued in setup
    logic        rd_ready;                              // RAM data for that read is on rd_row

    assign setup  = psel & ~penable;
    assign access = psel & penable;

    // paddr and access_kind are stable from setup through the access phase,
    // so the decode below stays valid for the whole transfer
    assign win_addr  = paddr - dmem_base;               // wraps high for addresses below base
    assign in_window = (win_addr[31:MEM_ADDR_WIDTH] == '0);
    assign kind_ok   = kind_valid(access_kind);
    assign kind      = access_kind_e'(access_kind);

    assign align_mask = 2'(kind_size_bytes(kind) - 3'd1);   // 0, 1 or 3
    assign aligned    = ((win_addr[1:0] & align_mask) == 2'b00);
    assign legal      = in_window & kind_ok & aligned;

    assign row    = win_addr[MEM_ADDR_WIDTH-1:2];
    assign offset = win_addr[1:0];                      // equal to paddr[1:0], the base is aligned

    // the RAM read starts in the setup cycle so its data is registered by
    // the first access edge and is held through the second access cycle
    assign rd_en = setup & ~pwrite & legal;
    assign wr_en = access & pwrite & legal;             // writes finish in the first access cycle

    // read sequencing, one read in flight at most since APB has no overlap
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pending <= 1'b0;
            rd_ready   <= 1'b0;
        end else if (rd_en) begin
            rd_pending <= 1'b1;                         // row goes into the RAM on this edge
            rd_ready   <= 1'b0;
        end else if (access && rd_ready) begin
            rd_pending <= 1'b0;                         // transfer completes this cycle
            rd_ready   <= 1'b0;
        end else if (access && rd_pending) begin
            rd_ready   <= 1'b1;                         // wait state is over after this edge
        end else if (!psel) begin
            rd_pending <= 1'b0;                         // host dropped the transfer
            rd_ready   <= 1'b0;
        end
    end

    // writes and errors need no wait state, a legal read waits for rd_ready
    assign pready  = access & (pwrite | ~legal | rd_ready);
    assign pslverr = access & ~legal;                   // only seen together with pready

endmodule : dmem_apb_slave

`default_nettype wire

/* src/dmem_lane_align.sv */
`timescale 1ns/1ns
`default_nettype none

module dmem_lane_align (
    input  wire logic [1:0]               offset,     // byte offset of the access inside the row
    input  wire access_pkg::access_kind_e kind,       // load/store kind of the access
    input  wire logic [31:0]              wdata,      // store data, right aligned as the core sends it
    output access_pkg::lane_word_u        wr_lanes,   // store data replicated into the byte lanes
    output logic [3:0]                    byte_en,    // lanes the store is allowed to change
    input  wire access_pkg::lane_word_u   rd_row,     // row delivered by the RAM
    output logic [31:0]                   load_data   // extracted and extended load result
);

    import access_pkg::*;

    logic [2:0]  size;                         // access size in bytes, 1, 2 or 4
    logic        is_signed;                    // sign extension wanted by lb and lh
    logic [7:0]  sel_byte;                     // byte lane chosen by the offset
    logic [15:0] sel_half;                     // halfword lane chosen by offset bit 1
    logic        byte_ext;                     // fill bit for a byte load
    logic        half_ext;                     // fill bit for a halfword load

    assign size      = kind_size_bytes(kind);
    assign is_signed = kind_is_signed(kind);

    // for stores the value is copied into every lane of its size and the
    // enables pick the lanes that the offset points at
    always_comb begin
        wr_lanes = wdata;                      // word stores go through unchanged
        byte_en  = 4'b1111;
        case (size)
            3'd1: begin
                for (int i = 0; i < 4; i++) begin
                    wr_lanes.bytes[i] = wdata[7:0];   // same byte in all four lanes
                end
                byte_en = 4'b0001 << offset;
            end
            3'd2: begin
                wr_lanes.halves[0] = wdata[15:0];     // same halfword in both halves
                wr_lanes.halves[1] = wdata[15:0];
                byte_en = 4'b0011 << offset;          // offset is 0 or 2 once aligned
            end
            default: begin
            end
        endcase
    end

    // for loads the slave keeps offset and kind steady through the access
    // phase, so the selection matches the row that the RAM registered
    assign sel_byte = rd_row.bytes[offset];
    assign sel_half = rd_row.halves[offset[1]];
    assign byte_ext = is_signed & sel_byte[7];        // zero fill for lbu
    assign half_ext = is_signed & sel_half[15];       // zero fill for lhu

    always_comb begin
        case (size)
            3'd1:    load_data = {{24{byte_ext}}, sel_byte};
            3'd2:    load_data = {{16{half_ext}}, sel_half};
            default: load_data = rd_row;              // whole row for lw
        endcase
    end

endmodule : dmem_lane_align

`default_nettype wire

/* src/dmem_byte_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module dmem_byte_ram #(
    parameter int MEM_ADDR_WIDTH = 12                 // window width in byte address bits
) (
    input  wire logic                      clk,
    input  wire logic [MEM_ADDR_WIDTH-3:0] row,       // row index shared by reads and writes
    input  wire logic                      wr_en,     // write strobe for the enabled lanes
    input  wire logic [3:0]                byte_en,   // one enable per byte lane
    input  wire access_pkg::lane_word_u    wr_lanes,  // data already steered into its lanes
    input  wire logic                      rd_en,     // registers the addressed row
    output access_pkg::lane_word_u         rd_row     // row read on the last rd_en edge
);

    localparam int rows = 2 ** (MEM_ADDR_WIDTH - 2);  // four bytes per row

    // each lane is its own bank, so a byte store touches only one of them
    // and the write maps onto a byte-enabled block RAM
    for (genvar lane = 0; lane < 4; lane++) begin : bank_g
        logic [7:0] mem [0:rows-1];                    // contents start unknown since nothing is preloaded
        logic [7:0] q;                                 // read register of this bank

        always_ff @(posedge clk) begin
            if (wr_en && byte_en[lane]) begin
                mem[row] <= wr_lanes.bytes[lane];      // only this lane of the row changes
            end
            if (rd_en) begin
                q <= mem[row];                         // q holds its value while rd_en is low
            end
        end
    end

    // the slave never raises rd_en and wr_en in the same cycle, so a read
    // never races a write to the same row
    assign rd_row.bytes = {bank_g[3].q, bank_g[2].q, bank_g[1].q, bank_g[0].q};

endmodule : dmem_byte_ram

`default_nettype wire

/* src/access_pkg.sv */
`default_nettype none

package access_pkg;

    typedef enum logic [2:0] {
        kind_lb  = 3'b000,          // signed byte, also the byte store
        kind_lh  = 3'b001,          // signed halfword, also the halfword store
        kind_lw  = 3'b010,          // full word in both directions
        kind_lbu = 3'b100,          // unsigned byte
        kind_lhu = 3'b101           // unsigned halfword
    } access_kind_e;                // codes follow the RV32 load/store funct3

    // one RAM row, seen by the lane logic either as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  bytes;    // bytes[0] sits at the lowest address
        logic [1:0][15:0] halves;   // halves[0] covers bytes 0 and 1
    } lane_word_u;

    function automatic logic kind_valid(input logic [2:0] code);
        return (code == kind_lb) || (code == kind_lh) || (code == kind_lw) ||
               (code == kind_lbu) || (code == kind_lhu);   // 011, 110 and 111 are unused
    endfunction

    function automatic logic [2:0] kind_size_bytes(input access_kind_e kind);
        case (kind)
            kind_lb, kind_lbu: return 3'd1;   // single byte lane
            kind_lh, kind_lhu: return 3'd2;   // two neighbouring lanes
            default:           return 3'd4;   // words and unused codes take the whole row
        endcase
    endfunction

    function automatic logic kind_is_signed(input access_kind_e kind);
        return (kind == kind_lb) || (kind == kind_lh);   // a word needs no extension
    endfunction

endpackage : access_pkg

`default_nettype wire

/* src/mem_map_pkg.sv */
`default_nettype none

// address map of the data memory subsystem
// the core sees one flat 32-bit byte address space, and the scratch RAM
// answers only inside the window that starts at dmem_base
package mem_map_pkg;

    // first byte of the data window, aligned so that the low address bits
    // carry the offset into the RAM directly
    localparam logic [31:0] dmem_base = 32'h0001_0000;   // window starts at 64 KiB

    // number of address bits decoded inside the window
    // 12 bits gives 4096 bytes, which is 1024 rows of four byte lanes
    localparam int dmem_addr_width_dflt = 12;            // default window width in bits

    // the window size is 2**width bytes; any width from 4 to 16 keeps the
    // window clear of the base and leaves at least four rows in the RAM
    // the upper address bits above the width must match the base exactly,
    // so an access one byte past the window end is already outside it
    // the two lowest bits of any address select the byte lane in a row
    // and the remaining window bits select the row itself
    // the base is a multiple of four, so the lane bits of paddr and of the
    // window offset are always the same
    // addresses below the base wrap around in the subtraction and land far
    // above the window, so one compare covers both sides

endpackage : mem_map_pkg

`default_nettype wire
